//--- branch_cluster.f
+incdir+include
src/branch_pkg.sv
src/branch_queue.sv
src/branch_unit.sv
src/recovery_fsm.sv
src/flush_timer.sv
src/branch_cluster.sv
verif/branch_cluster_assertions.sv
verif/branch_cluster_tb.sv

//--- include/branch_cluster_config.svh
`ifndef BRANCH_CLUSTER_CONFIG_SVH
`define BRANCH_CLUSTER_CONFIG_SVH

// Data and address width
`define BC_XLEN 32

// Queue depths
`define BC_OPQ_DEPTH 4
`define BC_RESQ_DEPTH 2

// Cycles of refused input after a redirect
`define BC_FLUSH_CYCLES 3

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the branch cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f branch_cluster.f --top-module branch_cluster_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned status $status"
    exit 1
fi

output=$(./obj_dir/Vbranch_cluster_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- src/branch_cluster.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cluster_config.svh"

module branch_cluster (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              op_valid,
    output logic                   op_ready,
    input  branch_pkg::branch_op_t op_data,
    output logic                   res_valid,
    input  wire logic              res_ready,
    output branch_pkg::resolve_t   res_data,
    output logic                   redirect_valid,
    output branch_pkg::redirect_t  redirect
);

    logic                   opq_in_valid;
    logic                   opq_in_ready;
    logic                   opq_out_valid;
    logic                   opq_out_ready;
    branch_pkg::branch_op_t opq_out_data;
    logic                   bu_out_valid;
    logic                   bu_out_ready;
    branch_pkg::resolve_t   bu_out_data;
    logic                   flush;
    logic                   start;
    logic                   done;
    logic                   accept_enable;

    // Input closed while recovering
    assign op_ready     = opq_in_ready & accept_enable;
    assign opq_in_valid = op_valid & accept_enable;

    branch_queue #(
        .payload_t (branch_pkg::branch_op_t),
        .DEPTH     (`BC_OPQ_DEPTH)
    ) u_op_queue (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (opq_in_valid),
        .in_ready  (opq_in_ready),
        .in_data   (op_data),
        .out_valid (opq_out_valid),
        .out_ready (opq_out_ready),
        .out_data  (opq_out_data)
    );

    branch_unit u_branch_unit (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (opq_out_valid),
        .in_ready  (opq_out_ready),
        .in_data   (opq_out_data),
        .out_valid (bu_out_valid),
        .out_ready (bu_out_ready),
        .out_data  (bu_out_data)
    );

    branch_queue #(
        .payload_t (branch_pkg::resolve_t),
        .DEPTH     (`BC_RESQ_DEPTH)
    ) u_res_queue (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (bu_out_valid),
        .in_ready  (bu_out_ready),
        .in_data   (bu_out_data),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (res_data)
    );

    recovery_fsm u_recovery_fsm (
        .clock          (clock),
        .reset          (reset),
        .res_fire       (res_valid && res_ready),
        .res_data       (res_data),
        .done           (done),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .start          (start),
        .accept_enable  (accept_enable)
    );

    flush_timer u_flush_timer (
        .clock (clock),
        .reset (reset),
        .start (start),
        .done  (done)
    );

endmodule

`default_nettype wire

//--- src/branch_pkg.sv
`default_nettype none

`include "branch_cluster_config.svh"

package branch_pkg;

    localparam int TAG_W = 6;

    // Same values as RISC-V funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_cond_e;

    typedef struct packed {
        logic [`BC_XLEN-1:0] pc;
        logic [`BC_XLEN-1:0] opa;
        logic [`BC_XLEN-1:0] opb;
        logic [`BC_XLEN-1:0] imm;
        br_cond_e            cond;
        logic                is_jal;     // Overrides cond
        logic                pred_taken;
        logic [TAG_W-1:0]    dest_tag;
    } branch_op_t;

    typedef struct packed {
        logic [`BC_XLEN-1:0] pc;
        logic [`BC_XLEN-1:0] next_pc;    // Target or pc+4
        logic                taken;
        logic                mispredict;
        logic [TAG_W-1:0]    dest_tag;
    } resolve_t;

    typedef struct packed {
        logic [`BC_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

//--- src/branch_queue.sv
`timescale 1ns/1ns
`default_nettype none

module branch_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic flush,
    input  wire logic in_valid,
    output logic      in_ready,
    input  payload_t  in_data,
    output logic      out_valid,
    input  wire logic out_ready,
    output payload_t  out_data
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != cnt_w'(DEPTH));
    assign out_valid = (count != '0) && !flush;   // Nothing leaves while flushing
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + ptr_w'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + ptr_w'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- src/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cluster_config.svh"

module branch_unit (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              flush,
    input  wire logic              in_valid,
    output logic                   in_ready,
    input  branch_pkg::branch_op_t in_data,
    output logic                   out_valid,
    input  wire logic              out_ready,
    output branch_pkg::resolve_t   out_data
);

    logic                 taken;
    logic [`BC_XLEN-1:0]  target;
    branch_pkg::resolve_t res_next;

    always_comb begin
        if (in_data.is_jal) begin
            taken = 1'b1;
        end else begin
            case (in_data.cond)
                branch_pkg::BEQ:  taken = (in_data.opa == in_data.opb);
                branch_pkg::BNE:  taken = (in_data.opa != in_data.opb);
                branch_pkg::BLT:  taken = ($signed(in_data.opa) < $signed(in_data.opb));
                branch_pkg::BGE:  taken = ($signed(in_data.opa) >= $signed(in_data.opb));
                branch_pkg::BLTU: taken = (in_data.opa < in_data.opb);
                branch_pkg::BGEU: taken = (in_data.opa >= in_data.opb);
                default:          taken = 1'b0;   // Undefined funct3
            endcase
        end
    end

    assign target = in_data.pc + in_data.imm;

    always_comb begin
        res_next.pc         = in_data.pc;
        res_next.next_pc    = taken ? target : in_data.pc + `BC_XLEN'(4);
        res_next.taken      = taken;
        res_next.mispredict = (taken != in_data.pred_taken);
        res_next.dest_tag   = in_data.dest_tag;
    end

    // Stage frees up when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_ready && in_valid) begin
            out_data <= res_next;
        end
    end

endmodule

`default_nettype wire

//--- src/flush_timer.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cluster_config.svh"

module flush_timer (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic start,
    output logic      done
);

    localparam int cnt_w = $clog2(`BC_FLUSH_CYCLES + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= cnt_w'(`BC_FLUSH_CYCLES);
        end else if (count != '0) begin
            count <= count - cnt_w'(1);
        end
    end

    assign done = (count == cnt_w'(1));   // Last cycle of the quiet period

endmodule

`default_nettype wire

//--- src/recovery_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module recovery_fsm (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             res_fire,
    input  branch_pkg::resolve_t  res_data,
    input  wire logic             done,
    output logic                  flush,
    output logic                  redirect_valid,
    output branch_pkg::redirect_t redirect,
    output logic                  start,
    output logic                  accept_enable
);

    typedef enum logic [1:0] {
        IDLE,
        REDIRECT,
        QUIET
    } state_t;

    state_t state;
    state_t next_state;
    logic   mispredict_out;
    logic   in_redirect;

    assign mispredict_out = res_fire && res_data.mispredict;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (mispredict_out) next_state = REDIRECT;
            REDIRECT: next_state = QUIET;
            QUIET:    if (done) next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= IDLE;
            accept_enable <= 1'b0;   // Opens on the first cycle out of reset
        end else begin
            state         <= next_state;
            accept_enable <= (next_state == IDLE);
        end
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && mispredict_out) begin
            redirect.target <= res_data.next_pc;
        end
    end

    // One cycle of redirect, flush and timer kick
    assign in_redirect    = (state == REDIRECT);
    assign flush          = in_redirect;
    assign redirect_valid = in_redirect;
    assign start          = in_redirect;

endmodule

`default_nettype wire

//--- verif/branch_cluster_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module branch_cluster_assertions (
    input wire logic                 clock,
    input wire logic                 reset,
    input wire logic                 op_ready,
    input wire logic                 res_valid,
    input wire logic                 res_ready,
    input wire branch_pkg::resolve_t res_data,
    input wire logic                 redirect_valid
);

    property res_held_until_taken;
        @(posedge clock) disable iff (reset)
            res_valid && !res_ready |=> res_valid && $stable(res_data);
    endproperty

    property single_cycle_redirect;
        @(posedge clock) disable iff (reset)
            redirect_valid |=> !redirect_valid;
    endproperty

    // Quiet period follows the redirect
    property input_closed_after_redirect;
        @(posedge clock) disable iff (reset)
            redirect_valid |=> !op_ready;
    endproperty

    res_hold_check: assert property (res_held_until_taken)
        else $error("res_valid dropped or res_data changed while res_ready was low");

    redirect_pulse_check: assert property (single_cycle_redirect)
        else $error("redirect_valid high on two consecutive cycles");

    quiet_check: assert property (input_closed_after_redirect)
        else $error("op_ready high on the cycle after a redirect");

endmodule

bind branch_cluster branch_cluster_assertions u_assertions (
    .clock          (clock),
    .reset          (reset),
    .op_ready       (op_ready),
    .res_valid      (res_valid),
    .res_ready      (res_ready),
    .res_data       (res_data),
    .redirect_valid (redirect_valid)
);

`default_nettype wire

//--- verif/branch_cluster_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cluster_config.svh"

module branch_cluster_tb;

    localparam int clock_period    = 100;
    localparam int reset_cycles    = 16;
    localparam int num_entries     = 24;
    localparam int watchdog_cycles = num_entries * (`BC_OPQ_DEPTH + `BC_FLUSH_CYCLES + 20);
    localparam logic [`BC_XLEN-1:0] sign_bit = 32'h8000_0000;

    typedef struct packed {
        branch_pkg::branch_op_t op;
        logic                   drain;   // Let the cluster empty before the next entry
    } stim_entry_t;

    logic                   clock;
    logic                   reset;
    logic                   op_valid;
    logic                   op_ready;
    branch_pkg::branch_op_t op_data;
    logic                   res_valid;
    logic                   res_ready;
    branch_pkg::resolve_t   res_data;
    logic                   redirect_valid;
    branch_pkg::redirect_t  redirect;

    stim_entry_t           stimulus [num_entries];
    int                    entry_count;
    branch_pkg::resolve_t  expected_q [$];   // Accepted ops not yet resolved
    integer                seed;
    int                    recovery_step;    // -1 outside recovery
    logic [`BC_XLEN-1:0]   redirect_target;

    branch_cluster branch_cluster_inst (
        .clock          (clock),
        .reset          (reset),
        .op_valid       (op_valid),
        .op_ready       (op_ready),
        .op_data        (op_data),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_data       (res_data),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    initial clock = 1'b0;
    always #(clock_period / 2) clock = ~clock;

    task automatic report_failure(string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("MISMATCH %s: expected 0x%h, actual 0x%h",
                                     name, expected, actual));
        end
    endtask

    // Branch rules taken straight from the ISA description
    function automatic branch_pkg::resolve_t expected_resolve(branch_pkg::branch_op_t op);
        branch_pkg::resolve_t r;
        logic                 t;
        case (op.cond)
            branch_pkg::BEQ:  t = (op.opa == op.opb);
            branch_pkg::BNE:  t = !(op.opa == op.opb);
            branch_pkg::BLT:  t = ((op.opa ^ sign_bit) < (op.opb ^ sign_bit));
            branch_pkg::BGE:  t = !((op.opa ^ sign_bit) < (op.opb ^ sign_bit));
            branch_pkg::BLTU: t = (op.opa < op.opb);
            branch_pkg::BGEU: t = !(op.opa < op.opb);
            default:          t = 1'b0;
        endcase
        if (op.is_jal) begin
            t = 1'b1;
        end
        r.pc         = op.pc;
        r.next_pc    = t ? op.pc + op.imm : op.pc + 32'd4;
        r.taken      = t;
        r.mispredict = (t ^ op.pred_taken);
        r.dest_tag   = op.dest_tag;
        return r;
    endfunction

    task automatic add_entry(logic [31:0] pc, logic [31:0] opa, logic [31:0] opb,
                             logic [31:0] imm, branch_pkg::br_cond_e cond, logic is_jal,
                             logic pred_taken, logic drain);
        stimulus[entry_count].op.pc         = pc;
        stimulus[entry_count].op.opa        = opa;
        stimulus[entry_count].op.opb        = opb;
        stimulus[entry_count].op.imm        = imm;
        stimulus[entry_count].op.cond       = cond;
        stimulus[entry_count].op.is_jal     = is_jal;
        stimulus[entry_count].op.pred_taken = pred_taken;
        stimulus[entry_count].op.dest_tag   = '0;
        stimulus[entry_count].drain         = drain;
        entry_count++;
    endtask

    task automatic check_resolve();
        branch_pkg::resolve_t exp;
        if (expected_q.size() == 0) begin
            report_failure("resolve came out with no accepted operation left in the model");
        end
        exp = expected_q.pop_front();
        check_value("res_data.pc", exp.pc, res_data.pc);
        check_value("res_data.next_pc", exp.next_pc, res_data.next_pc);
        check_value("res_data.taken", 32'(exp.taken), 32'(res_data.taken));
        check_value("res_data.mispredict", 32'(exp.mispredict), 32'(res_data.mispredict));
        check_value("res_data.dest_tag", 32'(exp.dest_tag), 32'(res_data.dest_tag));
        if (exp.mispredict) begin
            expected_q.delete();   // Younger ops never come out
            recovery_step   = 0;
            redirect_target = exp.next_pc;
        end
    endtask

    task automatic check_recovery();
        if (recovery_step == 0) begin
            check_value("redirect_valid", 32'd1, 32'(redirect_valid));
            check_value("redirect.target", redirect_target, redirect.target);
            check_value("op_ready", 32'd0, 32'(op_ready));
            recovery_step = 1;
        end else if (recovery_step > 0 && recovery_step <= `BC_FLUSH_CYCLES) begin
            check_value("redirect_valid", 32'd0, 32'(redirect_valid));
            check_value("op_ready", 32'd0, 32'(op_ready));
            recovery_step++;
        end else if (recovery_step > 0) begin
            check_value("op_ready", 32'd1, 32'(op_ready));   // Queues empty again
            recovery_step = -1;
        end else begin
            check_value("redirect_valid", 32'd0, 32'(redirect_valid));
        end
    endtask

    task automatic wait_for_drain();
        while (expected_q.size() != 0 || recovery_step != -1) begin
            @(posedge clock);
        end
        #1;
    endtask

    // Sampled at the falling edge ahead of the handshake
    always @(negedge clock) begin
        if (!reset) begin
            check_recovery();
            if (op_valid && op_ready) begin
                expected_q.push_back(expected_resolve(op_data));
            end
            if (res_valid && res_ready) begin
                check_resolve();
            end
        end
    end

    initial begin
        seed      = 32'h25fc_00ae;
        res_ready = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            res_ready = (($random(seed) % 4) != 0);
        end
    end

    initial begin
        @(negedge reset);
        #(watchdog_cycles * clock_period);
        report_failure("timeout: the cluster did not resolve every operation in time");
    end

    initial begin
        logic accepted;
        reset          = 1'b1;
        op_valid       = 1'b0;
        op_data        = '0;
        entry_count    = 0;
        recovery_step  = -1;
        redirect_target = '0;
        add_entry(32'h0000_1000, 32'h5, 32'h5, 32'h40, branch_pkg::BEQ, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1010, 32'h5, 32'h6, 32'h40, branch_pkg::BEQ, 1'b0, 1'b0, 1'b0);
        add_entry(32'h0000_1020, sign_bit, 32'h1, 32'h80, branch_pkg::BNE, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1030, 32'h7, 32'h7, 32'h80, branch_pkg::BNE, 1'b0, 1'b0, 1'b0);
        add_entry(32'h0000_1040, sign_bit, 32'h1, 32'h100, branch_pkg::BLT, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1050, 32'h1, sign_bit, 32'h100, branch_pkg::BLT, 1'b0, 1'b0, 1'b0);
        add_entry(32'h0000_1060, 32'hffff_ffff, 32'h0, 32'hffff_ffc0, branch_pkg::BLT,
                  1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1070, 32'h1, sign_bit, 32'h20, branch_pkg::BGE, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1080, sign_bit, 32'h1, 32'h20, branch_pkg::BGE, 1'b0, 1'b0, 1'b0);
        add_entry(32'h0000_1090, 32'h7fff_ffff, 32'h7fff_ffff, 32'h8, branch_pkg::BGE,
                  1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_10a0, 32'h1, sign_bit, 32'h400, branch_pkg::BLTU, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_10b0, sign_bit, 32'h1, 32'h400, branch_pkg::BLTU, 1'b0, 1'b0, 1'b0);
        add_entry(32'h0000_10c0, 32'h9, 32'h9, 32'h400, branch_pkg::BLTU, 1'b0, 1'b0, 1'b0);
        add_entry(32'h0000_10d0, sign_bit, 32'h1, 32'h10, branch_pkg::BGEU, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_10e0, 32'h0, 32'hffff_ffff, 32'h10, branch_pkg::BGEU,
                  1'b0, 1'b0, 1'b0);
        add_entry(32'h0000_10f0, 32'hffff_ffff, 32'hffff_ffff, 32'h10, branch_pkg::BGEU,
                  1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1100, 32'h0, 32'h0, 32'hffff_ff80, branch_pkg::BEQ, 1'b1, 1'b1, 1'b1);
        add_entry(32'h0000_1110, 32'h3, 32'h4, 32'h200, branch_pkg::BNE, 1'b0, 1'b0, 1'b0);
        add_entry(32'h0000_1120, 32'h0, 32'h0, 32'h30, branch_pkg::BEQ, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1130, 32'h0, 32'h0, 32'h30, branch_pkg::BEQ, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1140, 32'h0, 32'h0, 32'h30, branch_pkg::BEQ, 1'b0, 1'b1, 1'b0);
        add_entry(32'h0000_1150, 32'h0, 32'h0, 32'h30, branch_pkg::BEQ, 1'b0, 1'b1, 1'b1);
        add_entry(32'h0000_1160, 32'h1, 32'h2, 32'h60, branch_pkg::BGE, 1'b0, 1'b1, 1'b1);
        add_entry(32'h0000_1170, 32'h0, 32'h0, 32'h1000, branch_pkg::BEQ, 1'b1, 1'b0, 1'b1);

        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_value("op_ready", 32'd0, 32'(op_ready));
        check_value("res_valid", 32'd0, 32'(res_valid));
        check_value("redirect_valid", 32'd0, 32'(redirect_valid));
        @(negedge clock);
        check_value("op_ready", 32'd1, 32'(op_ready));   // Open on the first cycle after reset
        @(posedge clock);
        #1;

        for (int i = 0; i < num_entries; i++) begin
            op_data          = stimulus[i].op;
            op_data.dest_tag = 6'(i);
            op_valid         = 1'b1;
            accepted         = 1'b0;
            while (!accepted) begin
                @(negedge clock);
                accepted = op_ready;
                @(posedge clock);
                #1;
            end
            op_valid = 1'b0;
            if (stimulus[i].drain) begin
                wait_for_drain();
            end
        end

        wait_for_drain();
        repeat (4) @(posedge clock);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
